/* hw/cache_pkg.sv */
package cache_pkg;

    // byte address width, shared by CPU and memory side
    parameter int addr_bits = 16;

    // CPU side request, held until cpu_ready
    typedef struct packed {
        logic [addr_bits-1:0] addr;
        logic                 write;
        logic [31:0]          wdata;
    } cpu_req_t;

    // memory side request, address is word aligned
    typedef struct packed {
        logic [addr_bits-1:0] addr;
        logic                 write;
        logic [31:0]          wdata;
    } mem_req_t;

    // cache controller states
    typedef enum logic [1:0] {
        idle,
        compare_tag,
        write_back,
        allocate
    } cache_state_e;

endpackage

/* hw/dm_cache.sv */
module dm_cache #(
    parameter int index_bits = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t cpu_req,
    input  logic                cpu_valid,
    output logic                cpu_ready,
    output logic [31:0]         cpu_rdata,
    output cache_pkg::mem_req_t mem_req,
    output logic                mem_valid,
    input  logic [31:0]         mem_rdata,
    input  logic                mem_ready
);
    import cache_pkg::*;

    localparam int tag_bits  = addr_bits - index_bits - 2;
    localparam int num_lines = 1 << index_bits;

    // one line holds a single word
    typedef struct packed {
        logic                dirty;
        logic [tag_bits-1:0] tag;
        logic [31:0]         data;
    } line_t;

    cache_state_e state;
    cache_state_e next_state;

    cpu_req_t req_q;

    logic [num_lines-1:0] line_valid;
    line_t                lines [num_lines];

    logic [index_bits-1:0] req_index;
    logic [tag_bits-1:0]   req_tag;
    line_t                 cur_line;
    logic                  hit;
    logic                  victim_dirty;

    // bits 1:0 take no part in the split
    assign req_index = req_q.addr[index_bits+1:2];
    assign req_tag   = req_q.addr[addr_bits-1:index_bits+2];

    assign cur_line     = lines[req_index];
    assign hit          = line_valid[req_index] && (cur_line.tag == req_tag);
    assign victim_dirty = line_valid[req_index] && cur_line.dirty;

    // request captured as it leaves idle
    always_ff @(posedge clk)
    begin
        if (state == idle && cpu_valid)
        begin
            req_q <= cpu_req;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            idle:
            begin
                if (cpu_valid)
                begin
                    next_state = compare_tag;
                end
            end
            compare_tag:
            begin
                if (hit)
                begin
                    next_state = idle;
                end
                else if (victim_dirty)
                begin
                    next_state = write_back;
                end
                else
                begin
                    next_state = allocate;
                end
            end
            write_back:
            begin
                if (mem_ready)
                begin
                    next_state = allocate;
                end
            end
            allocate:
            begin
                // refill done so compare again and hit
                if (mem_ready)
                begin
                    next_state = compare_tag;
                end
            end
            default:
            begin
                next_state = idle;
            end
        endcase
    end

    // line data, tag and dirty bit
    always_ff @(posedge clk)
    begin
        if (state == compare_tag && hit && req_q.write)
        begin
            lines[req_index] <= '{dirty: 1'b1, tag: cur_line.tag, data: req_q.wdata};
        end
        else if (state == allocate && mem_ready)
        begin
            lines[req_index] <= '{dirty: 1'b0, tag: req_tag, data: mem_rdata};
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            line_valid <= '0;
        end
        else if (state == allocate && mem_ready)
        begin
            line_valid[req_index] <= 1'b1;
        end
    end

    assign cpu_ready = (state == compare_tag) && hit;
    assign cpu_rdata = cur_line.data;

    // victim address comes from the stored tag
    always_comb
    begin
        mem_req.addr  = {req_tag, req_index, 2'b00};
        mem_req.write = 1'b0;
        mem_req.wdata = cur_line.data;
        if (state == write_back)
        begin
            mem_req.addr  = {cur_line.tag, req_index, 2'b00};
            mem_req.write = 1'b1;
        end
    end

    // up from the first write_back or allocate cycle
    // low for a cycle after each ready pulse
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_valid <= 1'b0;
        end
        else if (mem_ready)
        begin
            mem_valid <= 1'b0;
        end
        else if (next_state == write_back || next_state == allocate)
        begin
            mem_valid <= 1'b1;
        end
    end

    a_ready_pulse: assert property (
        @(posedge clk) disable iff (rst)
        cpu_ready |=> !cpu_ready
    ) else $error("cpu_ready held for two cycles");

    a_no_mem_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        mem_valid |-> state != idle
    ) else $error("mem_valid high while idle");

    a_mem_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> $stable(mem_req)
    ) else $error("mem_req changed before mem_ready");

endmodule

/* hw/main_memory.sv */
module main_memory #(
    parameter int mem_latency = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::mem_req_t mem_req,
    input  logic                mem_valid,
    output logic                mem_ready,
    output logic [31:0]         mem_rdata
);
    import cache_pkg::*;

    localparam int word_bits = addr_bits - 2;
    localparam int num_words = 1 << word_bits;
    localparam int cnt_bits  = $clog2(mem_latency + 1);

    localparam logic [cnt_bits-1:0] last_count = cnt_bits'(mem_latency - 1);

    logic [31:0] words [num_words];

    logic [cnt_bits-1:0]  count;
    logic [word_bits-1:0] word_addr;
    logic                 fire;

    assign word_addr = mem_req.addr[addr_bits-1:2];

    // last waiting cycle, ready follows on the next edge
    assign fire = mem_valid && !mem_ready && (count == last_count);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count     <= '0;
            mem_ready <= 1'b0;
        end
        else
        begin
            mem_ready <= fire;
            if (fire)
            begin
                count <= '0;
            end
            else if (mem_valid && !mem_ready)
            begin
                count <= count + 1'b1;
            end
        end
    end

    // contents start from zero
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < num_words; i++)
            begin
                words[i] <= '0;
            end
        end
        else if (fire && mem_req.write)
        begin
            words[word_addr] <= mem_req.wdata;
        end
    end

    // read word lines up with the ready pulse
    always_ff @(posedge clk)
    begin
        if (fire)
        begin
            mem_rdata <= words[word_addr];
        end
    end

    a_valid_held: assert property (
        @(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid
    ) else $error("mem_valid dropped before mem_ready");

endmodule

/* hw/cache_subsystem_top.sv */
module cache_subsystem_top #(
    parameter int index_bits  = 4,
    parameter int mem_latency = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t cpu_req,
    input  logic                cpu_valid,
    output logic                cpu_ready,
    output logic [31:0]         cpu_rdata
);
    import cache_pkg::*;

    // cache to memory
    mem_req_t    mem_req;
    logic        mem_valid;
    logic        mem_ready;
    logic [31:0] mem_rdata;

    dm_cache #(
        .index_bits (index_bits)
    ) u_cache (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_valid (cpu_valid),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    main_memory #(
        .mem_latency (mem_latency)
    ) u_memory (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

endmodule

/* test/tb_clock.sv */
module tb_clock #(
    parameter int period       = 8,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(period / 2) clk = ~clk;
        end
    end

    // release on a falling edge, away from the sampling edge
    initial
    begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* test/tb_cache.sv */
module tb_cache;
    import cache_pkg::*;

    localparam int index_bits         = 4;
    localparam int mem_latency        = 3;
    localparam int clk_period         = 8;
    localparam int reset_cycles       = 10;
    localparam int num_lines          = 1 << index_bits;
    localparam int directed_requests  = 8;
    localparam int random_requests    = 200;
    localparam int total_requests     = directed_requests + random_requests;
    localparam int cycles_per_request = 40;
    localparam int miss_min_cycles    = 2 + mem_latency + 2;

    logic        clk;
    logic        rst;
    cpu_req_t    cpu_req;
    logic        cpu_valid;
    logic        cpu_ready;
    logic [31:0] cpu_rdata;

    // expectations for the request in flight, changed on falling edges only
    int          req_wait;
    logic        expect_hit;
    logic [31:0] exp_rdata;
    logic        seen_valid;

    // shadow of memory contents, missing entries read as zero
    logic [31:0]          shadow [logic [addr_bits-3:0]];
    logic [addr_bits-3:0] last_word [num_lines];
    logic [num_lines-1:0] index_seen;
    int                   requests_done;

    logic [31:0] lfsr_state;

    tb_clock #(
        .period       (clk_period),
        .reset_cycles (reset_cycles)
    ) u_clock (
        .clk (clk),
        .rst (rst)
    );

    cache_subsystem_top #(
        .index_bits  (index_bits),
        .mem_latency (mem_latency)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_valid (cpu_valid),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata)
    );

    function automatic logic [addr_bits-3:0] word_of(input logic [addr_bits-1:0] addr);
        return addr[addr_bits-1:2];
    endfunction

    function automatic logic [index_bits-1:0] index_of(input logic [addr_bits-1:0] addr);
        return addr[index_bits+1:2];
    endfunction

    function automatic logic [31:0] step_lfsr(input logic [31:0] state);
        if (state[0])
        begin
            return (state >> 1) ^ 32'hb4bc_d35c;
        end
        return state >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = step_lfsr(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic report_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "value check failed");
    endtask

    task automatic report_violation(input string msg);
        $display("protocol violation at time %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "protocol check failed");
    endtask

    // called on a falling edge, returns on the falling edge after the ready pulse
    task automatic issue_request(
        input logic [addr_bits-1:0] addr,
        input logic                 write,
        input logic [31:0]          wdata
    );
        logic [addr_bits-3:0]  word;
        logic [index_bits-1:0] index;
        word       = word_of(addr);
        index      = index_of(addr);
        expect_hit = index_seen[index] && (last_word[index] == word);
        if (shadow.exists(word))
        begin
            exp_rdata = shadow[word];
        end
        else
        begin
            exp_rdata = '0;
        end
        cpu_req.addr  = addr;
        cpu_req.write = write;
        cpu_req.wdata = wdata;
        cpu_valid     = 1'b1;
        seen_valid    = 1'b1;
        req_wait      = 1;
        while (!cpu_ready)
        begin
            @(negedge clk);
            req_wait = req_wait + 1;
        end
        @(negedge clk);
    endtask

    task automatic run_directed();
        logic [addr_bits-1:0] addr_a;
        logic [addr_bits-1:0] addr_b;
        logic [addr_bits-1:0] addr_c;
        // same index, two tags
        addr_a      = addr_bits'((1 << (index_bits + 2)) | (5 << 2));
        addr_b      = addr_bits'((2 << (index_bits + 2)) | (5 << 2));
        addr_c      = addr_a;
        addr_c[1:0] = 2'b11;
        issue_request(addr_a, 1'b1, 32'hcafe_0001);
        // dirty victim goes back to memory here
        issue_request(addr_b, 1'b0, '0);
        issue_request(addr_a, 1'b0, '0);
        issue_request(addr_a, 1'b0, '0);
        issue_request(addr_c, 1'b1, 32'h1234_5678);
        issue_request(addr_a, 1'b0, '0);
        issue_request(addr_b, 1'b1, 32'h0bad_f00d);
        issue_request(addr_a, 1'b0, '0);
        cpu_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic run_random();
        logic [31:0]          tag;
        logic [31:0]          index;
        logic [31:0]          low;
        logic [31:0]          write;
        logic [31:0]          wdata;
        logic [31:0]          gap;
        logic [addr_bits-1:0] addr;
        for (int n = 0; n < random_requests; n++)
        begin
            // four tags over four lines keeps hits and evictions frequent
            tag   = next_bits(2);
            index = next_bits(2);
            low   = next_bits(2);
            write = next_bits(1);
            wdata = next_bits(32);
            gap   = next_bits(1);
            addr  = addr_bits'((tag << (index_bits + 2)) | (index << 2) | low);
            issue_request(addr, write[0], wdata);
            if (gap[0])
            begin
                cpu_valid = 1'b0;
                @(negedge clk);
            end
        end
        cpu_valid = 1'b0;
    endtask

    // tracker, updated at each ready pulse
    always @(posedge clk)
    begin
        if (rst)
        begin
            index_seen    = '0;
            requests_done = 0;
        end
        else if (cpu_valid && cpu_ready)
        begin
            if (cpu_req.write)
            begin
                shadow[word_of(cpu_req.addr)] = cpu_req.wdata;
            end
            last_word[index_of(cpu_req.addr)]  = word_of(cpu_req.addr);
            index_seen[index_of(cpu_req.addr)] = 1'b1;
            requests_done = requests_done + 1;
        end
    end

    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (rst)
        !seen_valid |-> !cpu_ready
    ) else report_violation("cpu_ready raised before any request");

    a_ready_with_valid: assert property (
        @(posedge clk) disable iff (rst)
        cpu_ready |-> cpu_valid
    ) else report_violation("cpu_ready raised while cpu_valid was low");

    a_ready_single: assert property (
        @(posedge clk) disable iff (rst)
        cpu_ready |=> !cpu_ready
    ) else report_violation("cpu_ready stayed high for two cycles");

    a_read_data: assert property (
        @(posedge clk) disable iff (rst)
        cpu_valid && cpu_ready && !cpu_req.write |-> cpu_rdata == exp_rdata
    ) else report_error($sformatf("read of %h returned %h, expected %h",
                                  cpu_req.addr, cpu_rdata, exp_rdata));

    a_hit_latency: assert property (
        @(posedge clk) disable iff (rst)
        cpu_valid && expect_hit |-> cpu_ready == (req_wait == 2)
    ) else report_error($sformatf("hit on %h, ready %0b in cycle %0d, expected cycle 2",
                                  cpu_req.addr, cpu_ready, req_wait));

    a_miss_latency: assert property (
        @(posedge clk) disable iff (rst)
        cpu_valid && !expect_hit && cpu_ready |-> req_wait >= miss_min_cycles
    ) else report_error($sformatf("miss on %h answered in cycle %0d, expected %0d or later",
                                  cpu_req.addr, req_wait, miss_min_cycles));

    initial
    begin
        repeat (reset_cycles + cycles_per_request * total_requests) @(posedge clk);
        $display("timeout: the cache stopped answering after %0d of %0d requests",
                 requests_done, total_requests);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        cpu_req    = '0;
        cpu_valid  = 1'b0;
        seen_valid = 1'b0;
        expect_hit = 1'b0;
        exp_rdata  = '0;
        req_wait   = 0;
        lfsr_state = 32'd78659;
        @(negedge rst);
        // idle a while so a stray ready would show
        repeat (4) @(negedge clk);
        run_directed();
        run_random();
        repeat (3) @(negedge clk);
        if (requests_done == total_requests)
        begin
            $display("STATUS: PASS");
            $finish;
        end
        else
        begin
            $display("only %0d of %0d requests completed", requests_done, total_requests);
            $display("STATUS: FAIL");
            $fatal(1, "request count mismatch");
        end
    end

endmodule

/* sim.f */
hw/cache_pkg.sv
hw/dm_cache.sv
hw/main_memory.sv
hw/cache_subsystem_top.sv
test/tb_clock.sv
test/tb_cache.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cache
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: simulate clean

# build and run, the exit status carries pass or fail
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
